//--- hw/fpu_types_pkg.sv
// data types for the fp compare/logic slot
// words with parity, opcodes, forwarding selects and compare flags
package fpu_types_pkg;

  typedef logic [31:0] word_t;
  // word plus even parity in the msb
  typedef logic [32:0] pword_t;
  localparam int PAR_BIT = 32;

  typedef enum logic [2:0] {
    FOP_CMPEQ = 3'd0,
    FOP_CMPLT = 3'd1,
    FOP_CMPLE = 3'd2,
    FOP_CMPUN = 3'd3,
    FOP_AND   = 3'd4,
    FOP_OR    = 3'd5,
    FOP_XOR   = 3'd6,
    FOP_ANDN  = 3'd7
  } fop_t;

  // value below the bus count picks a result bus, anything else the issue operand
  typedef logic [2:0] fwd_sel_t;

  typedef logic [3:0] cmp_flags_t;
  localparam int FLAG_UN = 3;
  localparam int FLAG_GT = 2;
  localparam int FLAG_LT = 1;
  localparam int FLAG_EQ = 0;

  typedef logic [1:0] cmp_sel_t;
  localparam cmp_sel_t CMP_EQ = 2'd0;
  localparam cmp_sel_t CMP_LT = 2'd1;
  localparam cmp_sel_t CMP_LE = 2'd2;
  localparam cmp_sel_t CMP_UN = 2'd3;

  typedef logic [1:0] logic_sel_t;
  localparam logic_sel_t LOG_AND  = 2'd0;
  localparam logic_sel_t LOG_OR   = 2'd1;
  localparam logic_sel_t LOG_XOR  = 2'd2;
  localparam logic_sel_t LOG_ANDN = 2'd3;

  // single precision field positions
  localparam int SIGN_BIT  = 31;
  localparam int EXP_HI    = 30;
  localparam int EXP_LO    = 23;
  localparam int QUIET_BIT = 22;

endpackage

//--- hw/fpu_csr_pkg.sv
// fp control/status register layout
// exception bits, CSR field positions and retirement codes
package fpu_csr_pkg;

  // invalid in bit 1, denormal operand in bit 0
  typedef logic [1:0] exc_t;
  localparam int EXC_INV = 1;
  localparam int EXC_DEN = 0;

  typedef logic [3:0] ret_t;
  localparam ret_t RET_NONE   = 4'd0;
  localparam ret_t RET_TRAP   = 4'd1;
  localparam ret_t RET_PARITY = 4'd2;

  // enable in [1:0], sticky status in [5:4], rest reads zero
  typedef logic [7:0] csr_t;
  localparam int CSR_EN_LO = 0;
  localparam int CSR_EN_HI = 1;
  localparam int CSR_ST_LO = 4;
  localparam int CSR_ST_HI = 5;

endpackage

//--- hw/operand_forward.sv
// operand forwarding stage
// picks each operand from the issue port or a result bus, checks parity
`timescale 1ns/1ps

module operand_forward
  import fpu_types_pkg::*;
#(
  parameter int NUM_BUSES = 4
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     issue_valid,
  input  pword_t   a,
  input  pword_t   b,
  input  fwd_sel_t fwd_a,
  input  fwd_sel_t fwd_b,
  input  pword_t   bus_data [NUM_BUSES],
  output logic     s1_valid,
  output word_t    s1_a,
  output word_t    s1_b,
  output logic     s1_par_err
);

  pword_t op_a;
  pword_t op_b;

  // out of range select falls back to the issue operand
  function automatic pword_t pick(input fwd_sel_t sel, input pword_t issue);
    pword_t v;
    v = issue;
    for (int i = 0; i < NUM_BUSES; i++) begin
      if (int'(sel) == i) begin
        v = bus_data[i];
      end
    end
    return v;
  endfunction

  always_comb begin
    op_a = pick(fwd_a, a);
    op_b = pick(fwd_b, b);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      s1_a       <= op_a[PAR_BIT-1:0];
      s1_b       <= op_b[PAR_BIT-1:0];
      // even parity, so odd xor means a flipped bit
      s1_par_err <= (^op_a) | (^op_b);
    end
  end

endmodule

//--- hw/fpu_decode.sv
// opcode decoder
// registers compare/logic controls alongside the stage 1 operands
`timescale 1ns/1ps

module fpu_decode
  import fpu_types_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       issue_valid,
  input  fop_t       op,
  output logic       s1_is_logic,
  output cmp_sel_t   s1_cmp_sel,
  output logic       s1_signal_nan,
  output logic_sel_t s1_logic_sel
);

  logic       is_logic_d;
  cmp_sel_t   cmp_sel_d;
  logic       signal_nan_d;
  logic_sel_t logic_sel_d;

  always_comb begin
    is_logic_d   = 1'b0;
    cmp_sel_d    = CMP_EQ;
    signal_nan_d = 1'b0;
    logic_sel_d  = LOG_AND;
    case (op)
      FOP_CMPEQ: cmp_sel_d = CMP_EQ;
      FOP_CMPLT: begin
        cmp_sel_d    = CMP_LT;
        signal_nan_d = 1'b1;
      end
      FOP_CMPLE: begin
        cmp_sel_d    = CMP_LE;
        signal_nan_d = 1'b1;
      end
      FOP_CMPUN: cmp_sel_d = CMP_UN;
      FOP_AND: begin
        is_logic_d  = 1'b1;
        logic_sel_d = LOG_AND;
      end
      FOP_OR: begin
        is_logic_d  = 1'b1;
        logic_sel_d = LOG_OR;
      end
      FOP_XOR: begin
        is_logic_d  = 1'b1;
        logic_sel_d = LOG_XOR;
      end
      FOP_ANDN: begin
        is_logic_d  = 1'b1;
        logic_sel_d = LOG_ANDN;
      end
      default: is_logic_d = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_is_logic   <= 1'b0;
      s1_cmp_sel    <= CMP_EQ;
      s1_signal_nan <= 1'b0;
      s1_logic_sel  <= LOG_AND;
    end else if (issue_valid) begin
      s1_is_logic   <= is_logic_d;
      s1_cmp_sel    <= cmp_sel_d;
      s1_signal_nan <= signal_nan_d;
      s1_logic_sel  <= logic_sel_d;
    end
  end

endmodule

//--- hw/fcmp_logic.sv
// single precision compare and bitwise logic
// produces result mask, compare flags and raised exceptions
`timescale 1ns/1ps

module fcmp_logic
  import fpu_types_pkg::*;
  import fpu_csr_pkg::*;
(
  input  word_t      s1_a,
  input  word_t      s1_b,
  input  logic       s1_is_logic,
  input  cmp_sel_t   s1_cmp_sel,
  input  logic       s1_signal_nan,
  input  logic_sel_t s1_logic_sel,
  output word_t      res,
  output cmp_flags_t flags,
  output exc_t       raise
);

  logic       a_nan, b_nan;
  logic       a_snan, b_snan;
  logic       both_zero;
  logic       unordered;
  logic       eq, lt;
  logic       pred;
  cmp_flags_t ord_flags;
  word_t      logic_res;

  function automatic logic is_nan(input word_t w);
    return (&w[EXP_HI:EXP_LO]) && (|w[QUIET_BIT:0]);
  endfunction

  function automatic logic is_denorm(input word_t w);
    return (~|w[EXP_HI:EXP_LO]) && (|w[QUIET_BIT:0]);
  endfunction

  assign a_nan     = is_nan(s1_a);
  assign b_nan     = is_nan(s1_b);
  // quiet bit clear marks a signaling nan
  assign a_snan    = a_nan && !s1_a[QUIET_BIT];
  assign b_snan    = b_nan && !s1_b[QUIET_BIT];
  assign both_zero = ~|{s1_a[EXP_HI:0], s1_b[EXP_HI:0]};
  assign unordered = a_nan || b_nan;

  // sign-magnitude ordering, +0 and -0 equal
  always_comb begin
    eq = (s1_a == s1_b) || both_zero;
    if (s1_a[SIGN_BIT] != s1_b[SIGN_BIT]) begin
      lt = s1_a[SIGN_BIT] && !both_zero;
    end else if (s1_a[SIGN_BIT]) begin
      lt = s1_a[EXP_HI:0] > s1_b[EXP_HI:0];
    end else begin
      lt = s1_a[EXP_HI:0] < s1_b[EXP_HI:0];
    end
  end

  always_comb begin
    ord_flags = '0;
    if (unordered) begin
      ord_flags[FLAG_UN] = 1'b1;
    end else begin
      ord_flags[FLAG_GT] = !eq && !lt;
      ord_flags[FLAG_LT] = lt;
      ord_flags[FLAG_EQ] = eq;
    end
  end

  always_comb begin
    case (s1_cmp_sel)
      CMP_EQ:  pred = ord_flags[FLAG_EQ];
      CMP_LT:  pred = ord_flags[FLAG_LT];
      CMP_LE:  pred = ord_flags[FLAG_LT] || ord_flags[FLAG_EQ];
      default: pred = ord_flags[FLAG_UN];
    endcase
  end

  always_comb begin
    case (s1_logic_sel)
      LOG_AND:  logic_res = s1_a & s1_b;
      LOG_OR:   logic_res = s1_a | s1_b;
      LOG_XOR:  logic_res = s1_a ^ s1_b;
      default:  logic_res = s1_a & ~s1_b;
    endcase
  end

  always_comb begin
    raise = '0;
    if (s1_is_logic) begin
      res   = logic_res;
      flags = '0;
    end else begin
      res   = {32{pred}};
      flags = ord_flags;
      raise[EXC_INV] = a_snan || b_snan || (s1_signal_nan && unordered);
      raise[EXC_DEN] = is_denorm(s1_a) || is_denorm(s1_b);
    end
  end

endmodule

//--- hw/fpu_writeback.sv
// writeback stage
// adds result parity, masks exceptions and forms the retirement code
`timescale 1ns/1ps

module fpu_writeback
  import fpu_types_pkg::*;
  import fpu_csr_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       s1_valid,
  input  logic       s1_par_err,
  input  word_t      res,
  input  cmp_flags_t flags,
  input  exc_t       raise,
  input  exc_t       exc_en,
  output logic       result_valid,
  output pword_t     result,
  output cmp_flags_t cmp_flags,
  output logic       ret_en,
  output ret_t       ret_code,
  output logic       raise_valid,
  output exc_t       raise_out
);

  logic trap;
  ret_t code_d;

  assign trap = |(raise & exc_en);

  // parity error takes priority over a trap
  always_comb begin
    if (s1_par_err) begin
      code_d = RET_PARITY;
    end else if (trap) begin
      code_d = RET_TRAP;
    end else begin
      code_d = RET_NONE;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
      ret_en       <= 1'b0;
      raise_valid  <= 1'b0;
    end else begin
      result_valid <= s1_valid;
      ret_en       <= s1_valid && (s1_par_err || trap);
      // corrupted operands must not touch sticky status
      raise_valid  <= s1_valid && !s1_par_err;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      result[PAR_BIT]     <= ^res;
      result[PAR_BIT-1:0] <= res;
      cmp_flags           <= flags;
      ret_code            <= code_d;
      raise_out           <= raise;
    end
  end

endmodule

//--- hw/fpu_csr.sv
// fp control/status register
// exception enables and sticky status, written by a one-cycle strobe
`timescale 1ns/1ps

module fpu_csr
  import fpu_csr_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic csr_we,
  input  csr_t csr_wdata,
  input  logic raise_valid,
  input  exc_t raise,
  output exc_t exc_en,
  output csr_t csr_rdata
);

  exc_t en_q;
  exc_t sticky_q;

  // write loads enables and clears sticky, beating a same-cycle raise
  always_ff @(posedge clk) begin
    if (rst) begin
      en_q     <= '0;
      sticky_q <= '0;
    end else if (csr_we) begin
      en_q     <= csr_wdata[CSR_EN_HI:CSR_EN_LO];
      sticky_q <= '0;
    end else if (raise_valid) begin
      sticky_q <= sticky_q | raise;
    end
  end

  assign exc_en = en_q;

  always_comb begin
    csr_rdata = '0;
    csr_rdata[CSR_EN_HI:CSR_EN_LO] = en_q;
    csr_rdata[CSR_ST_HI:CSR_ST_LO] = sticky_q;
  end

endmodule

//--- hw/fpu_unit.sv
// fp compare/logic execution slot
// two-stage pipeline: forward and decode, then compare/logic and writeback
`timescale 1ns/1ps

module fpu_unit
  import fpu_types_pkg::*;
  import fpu_csr_pkg::*;
#(
  parameter int NUM_BUSES = 4
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       issue_valid,
  input  fop_t       op,
  input  pword_t     a,
  input  pword_t     b,
  input  fwd_sel_t   fwd_a,
  input  fwd_sel_t   fwd_b,
  input  pword_t     bus_data [NUM_BUSES],
  input  logic       csr_we,
  input  csr_t       csr_wdata,
  output csr_t       csr_rdata,
  output logic       result_valid,
  output pword_t     result,
  output cmp_flags_t cmp_flags,
  output logic       ret_en,
  output ret_t       ret_code
);

  logic       s1_valid;
  word_t      s1_a;
  word_t      s1_b;
  logic       s1_par_err;
  logic       s1_is_logic;
  cmp_sel_t   s1_cmp_sel;
  logic       s1_signal_nan;
  logic_sel_t s1_logic_sel;
  word_t      res;
  cmp_flags_t flags;
  exc_t       raise;
  logic       raise_valid;
  exc_t       raise_wb;
  exc_t       exc_en;

  operand_forward #(
    .NUM_BUSES(NUM_BUSES)
  ) i_forward (
    .clk        (clk),
    .rst        (rst),
    .issue_valid(issue_valid),
    .a          (a),
    .b          (b),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b),
    .bus_data   (bus_data),
    .s1_valid   (s1_valid),
    .s1_a       (s1_a),
    .s1_b       (s1_b),
    .s1_par_err (s1_par_err)
  );

  fpu_decode i_decode (
    .clk          (clk),
    .rst          (rst),
    .issue_valid  (issue_valid),
    .op           (op),
    .s1_is_logic  (s1_is_logic),
    .s1_cmp_sel   (s1_cmp_sel),
    .s1_signal_nan(s1_signal_nan),
    .s1_logic_sel (s1_logic_sel)
  );

  fcmp_logic i_cmp (
    .s1_a         (s1_a),
    .s1_b         (s1_b),
    .s1_is_logic  (s1_is_logic),
    .s1_cmp_sel   (s1_cmp_sel),
    .s1_signal_nan(s1_signal_nan),
    .s1_logic_sel (s1_logic_sel),
    .res          (res),
    .flags        (flags),
    .raise        (raise)
  );

  fpu_writeback i_writeback (
    .clk         (clk),
    .rst         (rst),
    .s1_valid    (s1_valid),
    .s1_par_err  (s1_par_err),
    .res         (res),
    .flags       (flags),
    .raise       (raise),
    .exc_en      (exc_en),
    .result_valid(result_valid),
    .result      (result),
    .cmp_flags   (cmp_flags),
    .ret_en      (ret_en),
    .ret_code    (ret_code),
    .raise_valid (raise_valid),
    .raise_out   (raise_wb)
  );

  fpu_csr i_csr (
    .clk        (clk),
    .rst        (rst),
    .csr_we     (csr_we),
    .csr_wdata  (csr_wdata),
    .raise_valid(raise_valid),
    .raise      (raise_wb),
    .exc_en     (exc_en),
    .csr_rdata  (csr_rdata)
  );

endmodule

//--- test/fpu_unit_properties.sv
// timing properties of the fp compare/logic slot
// latency, retirement and result parity, bound into fpu_unit
`timescale 1ns/1ps

module fpu_unit_properties
  import fpu_types_pkg::*;
(
  input logic   clk,
  input logic   rst,
  input logic   issue_valid,
  input logic   result_valid,
  input logic   ret_en,
  input pword_t result
);

  int fail_count = 0;

  issue_latency: assert property (@(posedge clk) disable iff (rst)
    issue_valid |-> ##2 result_valid)
  else begin
    $error("result_valid did not follow issue_valid by two cycles");
    fail_count++;
  end

  // no result without a matching issue two cycles earlier
  result_origin: assert property (@(posedge clk) disable iff (rst)
    result_valid |-> $past(issue_valid, 2))
  else begin
    $error("result_valid without an issue two cycles before");
    fail_count++;
  end

  ret_with_result: assert property (@(posedge clk) disable iff (rst)
    ret_en |-> result_valid)
  else begin
    $error("ret_en raised without result_valid");
    fail_count++;
  end

  quiet_after_reset: assert property (@(posedge clk)
    ($past(rst) || $past(rst, 2)) |-> !result_valid)
  else begin
    $error("result_valid high during or just after reset");
    fail_count++;
  end

  result_parity: assert property (@(posedge clk) disable iff (rst)
    result_valid |-> !(^result))
  else begin
    $error("result parity bit wrong");
    fail_count++;
  end

endmodule

bind fpu_unit fpu_unit_properties i_props (.*);

//--- test/tb_fpu_unit.sv
// testbench for the fp compare/logic slot
// drives issues and CSR writes, checks retired results against a reference model
`timescale 1ns/1ps

module tb_fpu_unit
  import fpu_types_pkg::*;
  import fpu_csr_pkg::*;
();

  localparam int NB = 4;
  localparam int TIMEOUT = 200;

  logic       clk = 1'b0;
  logic       rst;
  logic       issue_valid;
  fop_t       op;
  pword_t     a;
  pword_t     b;
  fwd_sel_t   fwd_a;
  fwd_sel_t   fwd_b;
  pword_t     bus_data [NB];
  logic       csr_we;
  csr_t       csr_wdata;
  csr_t       csr_rdata;
  logic       result_valid;
  pword_t     result;
  cmp_flags_t cmp_flags;
  logic       ret_en;
  ret_t       ret_code;

  pword_t     q_res [$];
  cmp_flags_t q_flags [$];
  logic       q_ret_en [$];
  ret_t       q_code [$];

  logic [31:0] seed = 32'hf60f;
  exc_t        en_model = '0;
  exc_t        sticky_model = '0;
  string       cur_test = "reset";
  int          errors = 0;
  int          tests = 0;
  int          err_start = 0;
  int          total;
  // zeros, quiet nan, signaling nan, ones, denormal, infinity
  word_t specials [8] = '{32'h0000_0000, 32'h8000_0000, 32'h7fc0_0001, 32'hff80_0001,
                          32'h3f80_0000, 32'hbf80_0000, 32'h0000_0005, 32'h7f80_0000};

  fpu_unit #(
    .NUM_BUSES(NB)
  ) i_dut (.*);

  always #4 clk = ~clk;

  function automatic logic [31:0] next_rand();
    seed ^= seed << 13;
    seed ^= seed >> 17;
    seed ^= seed << 5;
    return seed;
  endfunction

  function automatic word_t pick_operand();
    logic [31:0] r;
    r = next_rand();
    if (r[1:0] == 2'd0) begin
      return specials[r[4:2]];
    end
    return next_rand();
  endfunction

  function automatic pword_t with_par(input word_t w);
    return {^w, w};
  endfunction

  function automatic pword_t bad_par(input word_t w);
    return {~^w, w};
  endfunction

  function automatic void model_op(input fop_t o, input word_t x, input word_t y,
                                   output word_t r, output cmp_flags_t f, output exc_t e);
    logic               xn;
    logic               yn;
    logic               hold;
    logic signed [32:0] kx;
    logic signed [32:0] ky;
    xn = (x[30:23] == 8'hff) && (x[22:0] != '0);
    yn = (y[30:23] == 8'hff) && (y[22:0] != '0);
    // signed key, so both zeros map to 0
    kx = x[31] ? -$signed({2'b00, x[30:0]}) : $signed({2'b00, x[30:0]});
    ky = y[31] ? -$signed({2'b00, y[30:0]}) : $signed({2'b00, y[30:0]});
    f = '0;
    e = '0;
    case (o)
      FOP_AND:  r = x & y;
      FOP_OR:   r = x | y;
      FOP_XOR:  r = x ^ y;
      FOP_ANDN: r = x & ~y;
      default: begin
        if (xn || yn) begin
          f = 4'b1000;
        end else if (kx > ky) begin
          f = 4'b0100;
        end else if (kx < ky) begin
          f = 4'b0010;
        end else begin
          f = 4'b0001;
        end
        case (o)
          FOP_CMPEQ: hold = f[0];
          FOP_CMPLT: hold = f[1];
          FOP_CMPLE: hold = f[1] | f[0];
          default:   hold = f[3];
        endcase
        r = {32{hold}};
        e[1] = (xn && !x[22]) || (yn && !y[22]) ||
               ((o == FOP_CMPLT || o == FOP_CMPLE) && (xn || yn));
        e[0] = (x[30:23] == 8'h00 && x[22:0] != '0) || (y[30:23] == 8'h00 && y[22:0] != '0);
      end
    endcase
  endfunction

  task automatic expect_equal(input string what, input logic [32:0] exp,
                              input logic [32:0] act);
    assert (act === exp) else begin
      $display("Error %s: %s expected %h actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic issue(input fop_t o, input pword_t pa, input pword_t pb,
                       input fwd_sel_t fa, input fwd_sel_t fb);
    pword_t     sa;
    pword_t     sb;
    word_t      r;
    cmp_flags_t f;
    exc_t       e;
    logic       perr;
    logic       trap;
    sa = (int'(fa) < NB) ? bus_data[fa] : pa;
    sb = (int'(fb) < NB) ? bus_data[fb] : pb;
    perr = (^sa) | (^sb);
    model_op(o, sa[31:0], sb[31:0], r, f, e);
    trap = |(e & en_model);
    q_res.push_back({^r, r});
    q_flags.push_back(f);
    q_ret_en.push_back(perr || trap);
    q_code.push_back(perr ? RET_PARITY : (trap ? RET_TRAP : RET_NONE));
    if (!perr) begin
      sticky_model |= e;
    end
    issue_valid = 1'b1;
    op = o;
    a = pa;
    b = pb;
    fwd_a = fa;
    fwd_b = fb;
    @(posedge clk);
    #1;
    issue_valid = 1'b0;
  endtask

  task automatic csr_write(input csr_t w);
    csr_we = 1'b1;
    csr_wdata = w;
    @(posedge clk);
    #1;
    csr_we = 1'b0;
    en_model = w[1:0];
    sticky_model = '0;
  endtask

  task automatic check_csr();
    csr_t exp;
    exp = '0;
    exp[5:4] = sticky_model;
    exp[1:0] = en_model;
    expect_equal("csr_rdata", exp, csr_rdata);
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (q_res.size() != 0 && n < TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (q_res.size() != 0) begin
      $display("timeout in %s, %0d results never retired", cur_test, q_res.size());
      $display("CHECKS FAILED");
      $finish;
    end else begin
      // sticky lands one cycle after the last retirement
      repeat (2) @(posedge clk);
      #1;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    err_start = errors;
  endtask

  task automatic end_test();
    drain();
    check_csr();
    tests++;
    $display("test %s done, %0d errors", cur_test, errors - err_start);
  endtask

  always @(negedge clk) begin
    if (!rst && result_valid) begin
      if (q_res.size() == 0) begin
        $display("Error %s: a result retired with no issue pending", cur_test);
        errors++;
      end else begin
        expect_equal("result", q_res.pop_front(), result);
        expect_equal("cmp_flags", q_flags.pop_front(), cmp_flags);
        expect_equal("ret_en", q_ret_en.pop_front(), ret_en);
        expect_equal("ret_code", q_code.pop_front(), ret_code);
      end
    end
  end

  initial begin
    rst = 1'b1;
    issue_valid = 1'b0;
    op = FOP_CMPEQ;
    a = '0;
    b = '0;
    fwd_a = 3'd7;
    fwd_b = 3'd7;
    csr_we = 1'b0;
    csr_wdata = '0;
    for (int i = 0; i < NB; i++) begin
      bus_data[i] = '0;
    end
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    begin_test("compare");
    for (int o = 0; o < 4; o++) begin
      for (int i = 0; i < 8; i++) begin
        for (int j = 0; j < 8; j++) begin
          issue(fop_t'(o), with_par(specials[i]), with_par(specials[j]), 3'd7, 3'd7);
        end
      end
      for (int k = 0; k < 16; k++) begin
        issue(fop_t'(o), with_par(pick_operand()), with_par(pick_operand()), 3'd7, 3'd7);
      end
    end
    end_test();

    begin_test("logic");
    for (int o = 4; o < 8; o++) begin
      for (int k = 0; k < 16; k++) begin
        issue(fop_t'(o), with_par(next_rand()), with_par(next_rand()), 3'd7, 3'd7);
      end
    end
    end_test();

    begin_test("forwarding");
    for (int s = 0; s < 8; s++) begin
      for (int i = 0; i < NB; i++) begin
        bus_data[i] = with_par(next_rand());
      end
      issue(FOP_XOR, with_par(next_rand()), with_par(next_rand()), 3'(s), 3'((s + 1) % 8));
      issue(FOP_CMPLE, with_par(pick_operand()), with_par(pick_operand()), 3'(s), 3'(s));
    end
    end_test();

    begin_test("exceptions");
    csr_write(8'h00);
    for (int pass = 0; pass < 2; pass++) begin
      // quiet nan under lt raises invalid, a tiny operand raises denormal
      issue(FOP_CMPLT, with_par(32'h7fc0_0000), with_par(32'h3f80_0000), 3'd7, 3'd7);
      issue(FOP_CMPEQ, with_par(32'h0000_0001), with_par(32'h0000_0000), 3'd7, 3'd7);
      issue(FOP_CMPUN, with_par(32'hff80_0001), with_par(32'h0000_0000), 3'd7, 3'd7);
      drain();
      check_csr();
      csr_write(8'h03);
      check_csr();
    end
    end_test();

    begin_test("parity");
    csr_write(8'h03);
    issue(FOP_CMPLT, bad_par(32'h7f80_0001), with_par(32'h0000_0001), 3'd7, 3'd7);
    bus_data[2] = bad_par(next_rand());
    issue(FOP_AND, with_par(next_rand()), with_par(next_rand()), 3'd2, 3'd7);
    issue(FOP_CMPEQ, with_par(32'h0000_0003), bad_par(32'h0000_0001), 3'd7, 3'd7);
    end_test();

    begin_test("back_to_back");
    csr_write(8'h01);
    for (int k = 0; k < 24; k++) begin
      issue(fop_t'(next_rand() % 8), with_par(pick_operand()), with_par(pick_operand()),
            3'd7, 3'd7);
    end
    end_test();

    total = errors + i_dut.i_props.fail_count;
    $display("%0d tests, %0d check errors, %0d assertion failures",
             tests, errors, i_dut.i_props.fail_count);
    if (total == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
hw/fpu_types_pkg.sv
hw/fpu_csr_pkg.sv
hw/operand_forward.sv
hw/fpu_decode.sv
hw/fcmp_logic.sv
hw/fpu_writeback.sv
hw/fpu_csr.sv
hw/fpu_unit.sv
test/fpu_unit_properties.sv
test/tb_fpu_unit.sv

//--- Bender.yml
package:
  name: fpu_unit

sources:
  - hw/fpu_types_pkg.sv
  - hw/fpu_csr_pkg.sv
  - hw/operand_forward.sv
  - hw/fpu_decode.sv
  - hw/fcmp_logic.sv
  - hw/fpu_writeback.sv
  - hw/fpu_csr.sv
  - hw/fpu_unit.sv
  - target: test
    files:
      - test/fpu_unit_properties.sv
      - test/tb_fpu_unit.sv
